//--- project.f
+incdir+src
src/axi_demux_pkg.sv
src/id_counters.sv
src/ar_route.sv
src/r_rr_arbiter.sv
src/axi_read_demux.sv
tests/tb_axi_read_demux.sv

//--- Bender.yml
package:
  name: axi_read_demux

export_include_dirs:
  - src

sources:
  - src/axi_demux_pkg.sv
  - src/id_counters.sv
  - src/ar_route.sv
  - src/r_rr_arbiter.sv
  - src/axi_read_demux.sv
  - target: test
    files:
      - tests/tb_axi_read_demux.sv

//--- tests/tb_axi_read_demux.sv
`timescale 1ns/1ns
`include "axi_demux_defs.svh"

module tb_axi_read_demux;
  import axi_demux_pkg::*;

  localparam int  num_mst         = `DEMUX_NUM_MST_PORTS;
  localparam time clk_period      = 8;
  localparam int  num_tests       = 6;
  localparam int  cycles_per_test = 200;
  localparam int  max_wait        = 20;

  logic                      clk_i;
  logic                      rst_ni;
  ar_sel_t                   slv_ar_i;
  logic                      slv_ar_valid_i;
  logic                      slv_ar_ready_o;
  r_chan_t                   slv_r_o;
  logic                      slv_r_valid_o;
  logic                      slv_r_ready_i;
  ar_chan_t [num_mst-1:0]    mst_ar_o;
  logic     [num_mst-1:0]    mst_ar_valid_o;
  logic     [num_mst-1:0]    mst_ar_ready_i;
  r_chan_t  [num_mst-1:0]    mst_r_i;
  logic     [num_mst-1:0]    mst_r_valid_i;
  logic     [num_mst-1:0]    mst_r_ready_o;

  integer seed;
  int     err_count;
  int     tests_run;
  int     tests_failed;

  axi_read_demux dut_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .slv_ar_i       ( slv_ar_i       ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_r_o        ( slv_r_o        ),
    .slv_r_valid_o  ( slv_r_valid_o  ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_r_i        ( mst_r_i        ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_ready_o  ( mst_r_ready_o  )
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  // ------------------------------------------------------------------
  // Reporting and stimulus helpers
  // ------------------------------------------------------------------
  task automatic flag_mismatch(input string msg);
    $display("** Error @ %0t ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic flag_failure(input string msg);
    $display("Failure at %0t ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("[%0t ns] %-22s ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t ns] %-22s FAILED", $time, name);
    end
  endtask

  function automatic logic [num_mst-1:0] port_mask(input int port);
    logic [num_mst-1:0] m;
    m       = '0;
    m[port] = 1'b1;
    return m;
  endfunction

  // Single-beat read with random address
  function automatic ar_chan_t rand_ar(input id_t id);
    ar_chan_t ar;
    logic [31:0] rnd;
    rnd     = $random(seed);
    ar.id   = id;
    ar.addr = rnd[`DEMUX_ADDR_WIDTH-1:0];
    ar.len  = '0;
    return ar;
  endfunction

  function automatic r_chan_t rand_beat(input id_t id, input logic last);
    r_chan_t beat;
    beat.id   = id;
    beat.data = $random(seed);
    beat.resp = 2'b00;
    beat.last = last;
    return beat;
  endfunction

  // Present an AR and wait for the slave handshake
  task automatic send_ar(input ar_chan_t ar, input int sel, output bit done);
    slv_ar_i.ar    = ar;
    slv_ar_i.sel   = select_t'(sel);
    slv_ar_valid_i = 1'b1;
    done           = 1'b0;
    for (int c = 0; c < max_wait && !done; c++) begin
      @(negedge clk_i);
      if (slv_ar_ready_o) begin
        done = 1'b1;
        if (mst_ar_valid_o !== port_mask(sel)) flag_mismatch("AR valid on wrong master");
        if (mst_ar_o[sel] !== ar) flag_mismatch("AR payload changed on master");
      end
      @(posedge clk_i);
      #1;
    end
    slv_ar_valid_i = 1'b0;
  endtask

  // Master model returns one R beat, checked at the slave side
  task automatic send_r(input int port, input r_chan_t beat, output bit done);
    mst_r_i[port]       = beat;
    mst_r_valid_i[port] = 1'b1;
    done                = 1'b0;
    for (int c = 0; c < max_wait && !done; c++) begin
      @(negedge clk_i);
      if (mst_r_ready_o[port]) begin
        done = 1'b1;
        if (slv_r_valid_o !== 1'b1) flag_mismatch("slave R valid low during transfer");
        if (slv_r_o !== beat) flag_mismatch("R beat changed on its way to slave");
      end
      @(posedge clk_i);
      #1;
    end
    mst_r_valid_i[port] = 1'b0;
    if (!done) flag_failure("R beat was never accepted at the slave port");
  endtask

  // AR already presented, must not reach any master
  task automatic expect_ar_stall(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      if (mst_ar_valid_o !== '0 || slv_ar_ready_o !== 1'b0) begin
        flag_mismatch("stalled AR reached a master port");
      end
      @(posedge clk_i);
      #1;
    end
  endtask

  // ------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------
  task automatic test_reset_state();
    int errs0;
    errs0 = err_count;
    @(negedge clk_i);
    if (mst_ar_valid_o !== '0) flag_mismatch("master AR valid high after reset");
    if (mst_r_ready_o !== '0) flag_mismatch("master R ready high after reset");
    if (slv_r_valid_o !== 1'b0) flag_mismatch("slave R valid high after reset");
    if (slv_ar_ready_o !== 1'b0) flag_mismatch("slave AR ready high after reset");
    @(posedge clk_i);
    #1;
    close_test("reset_state", errs0);
  endtask

  task automatic test_routing();
    int       errs0;
    ar_chan_t ar;
    bit       done;
    errs0 = err_count;
    for (int s = 0; s < num_mst; s++) begin
      // Distinct lookup IDs per port
      ar             = rand_ar(id_t'(s + 8));
      mst_ar_ready_i = ~port_mask(s);
      slv_ar_i.ar    = ar;
      slv_ar_i.sel   = select_t'(s);
      slv_ar_valid_i = 1'b1;
      repeat (2) begin
        @(negedge clk_i);
        if (mst_ar_valid_o !== port_mask(s)) flag_mismatch("AR valid not held on master");
        if (slv_ar_ready_o !== 1'b0) flag_mismatch("AR ready high while master stalls");
        @(posedge clk_i);
        #1;
      end
      mst_ar_ready_i = '1;
      send_ar(ar, s, done);
      if (!done) flag_failure("routed AR was never accepted");
      send_r(s, rand_beat(ar.id, 1'b1), done);
    end
    close_test("routing", errs0);
  endtask

  task automatic test_same_id_other_port();
    int       errs0;
    ar_chan_t ar0, ar1;
    bit       done;
    errs0 = err_count;
    ar0   = rand_ar(4'h5);
    ar1   = rand_ar(4'h5);
    send_ar(ar0, 0, done);
    if (!done) flag_failure("first AR to port 0 was never accepted");
    slv_ar_i.ar    = ar1;
    slv_ar_i.sel   = select_t'(1);
    slv_ar_valid_i = 1'b1;
    expect_ar_stall(4);
    // Last beat on port 0 frees the ID
    send_r(0, rand_beat(4'h5, 1'b1), done);
    send_ar(ar1, 1, done);
    if (!done) flag_failure("AR to port 1 stayed blocked after the last beat");
    send_r(1, rand_beat(4'h5, 1'b1), done);
    close_test("same_id_other_port", errs0);
  endtask

  task automatic test_same_id_same_port();
    int errs0;
    bit done;
    errs0 = err_count;
    repeat (3) begin
      send_ar(rand_ar(4'hE), 2, done);
      if (!done) flag_failure("AR with bound ID to same port was blocked");
    end
    // Drain
    repeat (3) send_r(2, rand_beat(4'hE, 1'b1), done);
    close_test("same_id_same_port", errs0);
  endtask

  task automatic test_counter_full();
    int       errs0;
    ar_chan_t ar4;
    bit       done;
    errs0 = err_count;
    repeat (3) begin
      send_ar(rand_ar(4'h3), 1, done);
      if (!done) flag_failure("AR before the counter filled was blocked");
    end
    // Other ID, other port, still held back
    ar4            = rand_ar(4'h4);
    slv_ar_i.ar    = ar4;
    slv_ar_i.sel   = select_t'(0);
    slv_ar_valid_i = 1'b1;
    expect_ar_stall(4);
    send_r(1, rand_beat(4'h3, 1'b1), done);
    send_ar(ar4, 0, done);
    if (!done) flag_failure("AR stayed blocked after the counter drained");
    repeat (2) send_r(1, rand_beat(4'h3, 1'b1), done);
    send_r(0, rand_beat(4'h4, 1'b1), done);
    close_test("counter_full", errs0);
  endtask

  task automatic test_r_arbitration();
    r_chan_t beats [2][2];
    int      ports [2];
    int      head  [2];
    r_chan_t held;
    int      errs0, last_port, got, n_xfer, cyc;
    errs0    = err_count;
    ports[0] = 0;
    ports[1] = 2;
    // Non-last beats, so the counters stay untouched
    for (int p = 0; p < 2; p++) begin
      for (int b = 0; b < 2; b++) begin
        beats[p][b] = rand_beat(id_t'(p), 1'b0);
      end
      head[p]           = 0;
      mst_r_i[ports[p]] = beats[p][0];
    end
    slv_r_ready_i = 1'b0;
    // First port alone, the grant settles on it
    mst_r_valid_i[ports[0]] = 1'b1;
    @(negedge clk_i);
    held = slv_r_o;
    if (slv_r_valid_o !== 1'b1) flag_mismatch("slave R valid low with beats pending");
    if (held !== beats[0][0]) flag_mismatch("slave beat is not the pending one");
    @(posedge clk_i);
    #1;
    // Second port joins with higher priority while the slave stalls
    mst_r_valid_i[ports[1]] = 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      if (slv_r_o !== held) flag_mismatch("slave beat changed under back-pressure");
      if (mst_r_ready_o !== '0) flag_mismatch("master R ready high under back-pressure");
      @(posedge clk_i);
      #1;
    end
    slv_r_ready_i = 1'b1;
    last_port     = -1;
    n_xfer        = 0;
    cyc           = 0;
    while (n_xfer < 4 && cyc < max_wait) begin
      @(negedge clk_i);
      got = -1;
      for (int p = 0; p < 2; p++) begin
        if (mst_r_ready_o === port_mask(ports[p])) got = p;
      end
      if (got < 0) begin
        flag_mismatch("no single master R grant");
      end else begin
        if (n_xfer == 0 && slv_r_o !== held) flag_mismatch("locked beat not sent first");
        if (slv_r_o !== beats[got][head[got]]) flag_mismatch("R beat corrupted");
        if (got == last_port) flag_mismatch("R grant did not alternate");
        last_port = got;
      end
      @(posedge clk_i);
      #1;
      if (got >= 0) begin
        n_xfer++;
        head[got]++;
        if (head[got] < 2) mst_r_i[ports[got]] = beats[got][head[got]];
        else mst_r_valid_i[ports[got]] = 1'b0;
      end
      cyc++;
    end
    if (n_xfer != 4) flag_failure("not all arbitrated beats reached the slave port");
    close_test("r_arbitration", errs0);
  endtask

  // ------------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------------
  initial begin
    seed           = 32'h3a803c88;
    err_count      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b1;
    mst_ar_ready_i = '1;
    mst_r_i        = '0;
    mst_r_valid_i  = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset_state();
    test_routing();
    test_same_id_other_port();
    test_same_id_same_port();
    test_counter_full();
    test_r_arbitration();
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Upper bound from test count and per-test budget
  initial begin
    #(num_tests * cycles_per_test * clk_period);
    $display("Watchdog expired, the tests did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- src/axi_read_demux.sv
`timescale 1ns/1ns
`include "axi_demux_defs.svh"

module axi_read_demux (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  // Slave port
  input  axi_demux_pkg::ar_sel_t                             slv_ar_i,
  input  logic                                               slv_ar_valid_i,
  output logic                                               slv_ar_ready_o,
  output axi_demux_pkg::r_chan_t                             slv_r_o,
  output logic                                               slv_r_valid_o,
  input  logic                                               slv_r_ready_i,
  // Master ports
  output axi_demux_pkg::ar_chan_t [`DEMUX_NUM_MST_PORTS-1:0] mst_ar_o,
  output logic                    [`DEMUX_NUM_MST_PORTS-1:0] mst_ar_valid_o,
  input  logic                    [`DEMUX_NUM_MST_PORTS-1:0] mst_ar_ready_i,
  input  axi_demux_pkg::r_chan_t  [`DEMUX_NUM_MST_PORTS-1:0] mst_r_i,
  input  logic                    [`DEMUX_NUM_MST_PORTS-1:0] mst_r_valid_i,
  output logic                    [`DEMUX_NUM_MST_PORTS-1:0] mst_r_ready_o
);
  import axi_demux_pkg::*;

  // Router to counters
  look_id_t lookup_id;
  select_t  lookup_sel;
  logic     occupied, full, push;
  // Arbiter to counters
  look_id_t pop_id;
  logic     pop;

  ar_route i_ar_route (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .slv_ar_i       ( slv_ar_i       ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .lookup_id_o    ( lookup_id      ),
    .lookup_sel_i   ( lookup_sel     ),
    .occupied_i     ( occupied       ),
    .full_i         ( full           ),
    .push_o         ( push           )
  );

  // Push uses the same ID and the AR's own select
  id_counters i_id_counters (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .lookup_id_i  ( lookup_id    ),
    .lookup_sel_o ( lookup_sel   ),
    .occupied_o   ( occupied     ),
    .full_o       ( full         ),
    .push_id_i    ( lookup_id    ),
    .push_sel_i   ( slv_ar_i.sel ),
    .push_i       ( push         ),
    .pop_id_i     ( pop_id       ),
    .pop_i        ( pop          )
  );

  r_rr_arbiter i_r_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .mst_r_i       ( mst_r_i       ),
    .mst_r_valid_i ( mst_r_valid_i ),
    .mst_r_ready_o ( mst_r_ready_o ),
    .slv_r_o       ( slv_r_o       ),
    .slv_r_valid_o ( slv_r_valid_o ),
    .slv_r_ready_i ( slv_r_ready_i ),
    .pop_o         ( pop           ),
    .pop_id_o      ( pop_id        )
  );

endmodule

//--- src/r_rr_arbiter.sv
`timescale 1ns/1ns
`include "axi_demux_defs.svh"

module r_rr_arbiter (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // Master R
  input  axi_demux_pkg::r_chan_t [`DEMUX_NUM_MST_PORTS-1:0] mst_r_i,
  input  logic                   [`DEMUX_NUM_MST_PORTS-1:0] mst_r_valid_i,
  output logic                   [`DEMUX_NUM_MST_PORTS-1:0] mst_r_ready_o,
  // Slave R
  output axi_demux_pkg::r_chan_t                            slv_r_o,
  output logic                                              slv_r_valid_o,
  input  logic                                              slv_r_ready_i,
  // Counter pop
  output logic                                              pop_o,
  output axi_demux_pkg::look_id_t                           pop_id_o
);
  import axi_demux_pkg::*;

  localparam int unsigned num_mst = `DEMUX_NUM_MST_PORTS;

  arb_state_e state_q, state_d;
  select_t    prio_q, prio_d;
  select_t    grant_q, grant_d;
  select_t    pick, sel;
  logic       found, r_valid, r_xfer;

  // First valid port at or after the priority pointer
  always_comb begin
    int unsigned idx;
    pick  = prio_q;
    found = 1'b0;
    for (int unsigned k = 0; k < num_mst; k++) begin
      idx = (prio_q + k) % num_mst;
      if (!found && mst_r_valid_i[idx]) begin
        found = 1'b1;
        pick  = select_t'(idx);
      end
    end
  end

  // ------------------------------------------------------------------
  // Merge onto slave port
  // ------------------------------------------------------------------
  // Locked grant wins over a fresh pick
  assign sel           = (state_q == LOCKED) ? grant_q : pick;
  assign r_valid       = (state_q == LOCKED) ? mst_r_valid_i[grant_q] : found;
  assign r_xfer        = r_valid && slv_r_ready_i;
  assign slv_r_o       = mst_r_i[sel];
  assign slv_r_valid_o = r_valid;

  always_comb begin
    for (int unsigned i = 0; i < num_mst; i++) begin
      mst_r_ready_o[i] = r_xfer && (sel == select_t'(i));
    end
  end

  // Last beat retires the read
  assign pop_o    = r_xfer && slv_r_o.last;
  assign pop_id_o = slv_r_o.id[`DEMUX_LOOK_BITS-1:0];

  // Lock while stalled, rotate after a transfer
  always_comb begin
    state_d = state_q;
    grant_d = grant_q;
    prio_d  = prio_q;
    if (r_xfer) begin
      state_d = IDLE;
      prio_d  = (sel == select_t'(num_mst - 1)) ? '0 : sel + 1'b1;
    end else if (r_valid) begin
      state_d = LOCKED;
      grant_d = sel;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      prio_q  <= '0;
      grant_q <= '0;
    end else begin
      state_q <= state_d;
      prio_q  <= prio_d;
      grant_q <= grant_d;
    end
  end

endmodule

//--- src/ar_route.sv
`timescale 1ns/1ns
`include "axi_demux_defs.svh"

module ar_route (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  // Slave AR
  input  axi_demux_pkg::ar_sel_t                             slv_ar_i,
  input  logic                                               slv_ar_valid_i,
  output logic                                               slv_ar_ready_o,
  // Master AR
  output axi_demux_pkg::ar_chan_t [`DEMUX_NUM_MST_PORTS-1:0] mst_ar_o,
  output logic                    [`DEMUX_NUM_MST_PORTS-1:0] mst_ar_valid_o,
  input  logic                    [`DEMUX_NUM_MST_PORTS-1:0] mst_ar_ready_i,
  // ID counter interface
  output axi_demux_pkg::look_id_t                            lookup_id_o,
  input  axi_demux_pkg::select_t                             lookup_sel_i,
  input  logic                                               occupied_i,
  input  logic                                               full_i,
  output logic                                               push_o
);
  import axi_demux_pkg::*;

  localparam int unsigned num_mst = `DEMUX_NUM_MST_PORTS;

  // Valid lock keeps a raised master valid up until the handshake
  logic lock_q, lock_d;
  logic ar_valid, ar_ready;
  logic id_ok;

  // Lookup on the low ID bits
  assign lookup_id_o = slv_ar_i.ar.id[`DEMUX_LOOK_BITS-1:0];

  // Free ID, or ID already bound to the same port
  assign id_ok = !occupied_i || (slv_ar_i.sel == lookup_sel_i);

  // ------------------------------------------------------------------
  // Handshake control
  // ------------------------------------------------------------------
  always_comb begin
    ar_valid       = 1'b0;
    slv_ar_ready_o = 1'b0;
    push_o         = 1'b0;
    lock_d         = lock_q;
    if (lock_q) begin
      // Decision already taken, wait for the master
      ar_valid = 1'b1;
      if (ar_ready) begin
        slv_ar_ready_o = 1'b1;
        push_o         = 1'b1;
        lock_d         = 1'b0;
      end
    end else if (slv_ar_valid_i && !full_i && id_ok) begin
      ar_valid = 1'b1;
      if (ar_ready) begin
        slv_ar_ready_o = 1'b1;
        push_o         = 1'b1;
      end else begin
        // Master stalls, hold the valid
        lock_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= lock_d;
    end
  end

  // ------------------------------------------------------------------
  // Steering
  // ------------------------------------------------------------------
  always_comb begin
    ar_ready = 1'b0;
    for (int unsigned i = 0; i < num_mst; i++) begin
      // Payload goes to every port
      mst_ar_o[i]       = slv_ar_i.ar;
      // Valid only on the selected one
      mst_ar_valid_o[i] = ar_valid && (slv_ar_i.sel == select_t'(i));
      if (slv_ar_i.sel == select_t'(i)) begin
        ar_ready = mst_ar_ready_i[i];
      end
    end
  end

endmodule

//--- src/id_counters.sv
`timescale 1ns/1ns
`include "axi_demux_defs.svh"

module id_counters (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Lookup for the AR router
  input  axi_demux_pkg::look_id_t lookup_id_i,
  output axi_demux_pkg::select_t  lookup_sel_o,
  output logic                    occupied_o,
  output logic                    full_o,
  // Push on AR transfer
  input  axi_demux_pkg::look_id_t push_id_i,
  input  axi_demux_pkg::select_t  push_sel_i,
  input  logic                    push_i,
  // Pop on last R beat
  input  axi_demux_pkg::look_id_t pop_id_i,
  input  logic                    pop_i
);
  import axi_demux_pkg::*;

  localparam int unsigned num_cnt = 2 ** `DEMUX_LOOK_BITS;
  localparam int unsigned cnt_w   = `DEMUX_CNT_WIDTH;

  // One counter and one bound port per lookup ID
  logic    [num_cnt-1:0][cnt_w-1:0] cnt_q, cnt_d;
  select_t [num_cnt-1:0]            sel_q;
  logic    [num_cnt-1:0]            push_en, pop_en, cnt_full;

  // ------------------------------------------------------------------
  // Lookup
  // ------------------------------------------------------------------
  assign lookup_sel_o = sel_q[lookup_id_i];
  assign occupied_o   = |cnt_q[lookup_id_i];
  // Any saturated counter blocks all new ARs
  assign full_o       = |cnt_full;

  // Decode strobes per counter
  always_comb begin
    for (int unsigned i = 0; i < num_cnt; i++) begin
      push_en[i]  = push_i && (push_id_i == look_id_t'(i));
      pop_en[i]   = pop_i && (pop_id_i == look_id_t'(i));
      cnt_full[i] = &cnt_q[i];
    end
  end

  // ------------------------------------------------------------------
  // Saturating up/down count
  // ------------------------------------------------------------------
  always_comb begin
    cnt_d = cnt_q;
    for (int unsigned i = 0; i < num_cnt; i++) begin
      // Push and pop together cancel out
      if (push_en[i] && !pop_en[i] && !cnt_full[i]) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end else if (pop_en[i] && !push_en[i] && (cnt_q[i] != '0)) begin
        cnt_d[i] = cnt_q[i] - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      sel_q <= '0;
    end else begin
      cnt_q <= cnt_d;
      // Remember port of the latest push
      for (int unsigned i = 0; i < num_cnt; i++) begin
        if (push_en[i]) begin
          sel_q[i] <= push_sel_i;
        end
      end
    end
  end

endmodule

//--- src/axi_demux_pkg.sv
`include "axi_demux_defs.svh"

package axi_demux_pkg;

  // Master port index
  typedef logic [$clog2(`DEMUX_NUM_MST_PORTS)-1:0] select_t;

  // Full ID and its lookup part
  typedef logic [`DEMUX_ID_WIDTH-1:0]  id_t;
  typedef logic [`DEMUX_LOOK_BITS-1:0] look_id_t;

  // AR channel payload
  typedef struct packed {
    id_t                          id;
    logic [`DEMUX_ADDR_WIDTH-1:0] addr;
    logic [7:0]                   len;
  } ar_chan_t;

  // R channel payload
  typedef struct packed {
    id_t                          id;
    logic [`DEMUX_DATA_WIDTH-1:0] data;
    logic [1:0]                   resp;
    logic                         last;
  } r_chan_t;

  // AR payload together with its target port
  typedef struct packed {
    ar_chan_t ar;
    select_t  sel;
  } ar_sel_t;

  // R arbiter grant state
  typedef enum logic {
    IDLE,
    LOCKED
  } arb_state_e;

endpackage

//--- src/axi_demux_defs.svh
`ifndef AXI_DEMUX_DEFS_SVH
`define AXI_DEMUX_DEFS_SVH

// Number of master ports behind the demux
`define DEMUX_NUM_MST_PORTS 3

// Full AXI ID width
`define DEMUX_ID_WIDTH 4

// Low ID bits used to pick an in-flight counter
`define DEMUX_LOOK_BITS 2

// In-flight counter width, full at all ones
`define DEMUX_CNT_WIDTH 2

// Address and data bus widths
`define DEMUX_ADDR_WIDTH 16
`define DEMUX_DATA_WIDTH 32

`endif
